/* wakeup_pkg.sv */
package wakeup_pkg;

    // ****************************************
    // physical register file
    // ****************************************
    localparam int PREG_WIDTH = 6;
    localparam int PREG_SIZE  = 64;

    typedef logic [PREG_WIDTH-1:0] preg_t; // physical rd / rs index

    // ****************************************
    // wakeup timing
    // ****************************************

    // wakeup fires this many cycles ahead of writeback:
    // select & wakeup, reg read, exec, wb
    localparam int WAKE_AHEAD = 2;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_COUNT, // waiting out the divide
        DIV_WAKE   // one-cycle wakeup strobe
    } div_state_t;

endpackage

/* wakeup_merge.sv */
module wakeup_merge #(
    parameter int ALU_SIZE      = 4,
    parameter int LOAD_PIPELINE = 2
) (
    input  logic                                  [ALU_SIZE-1:0]               alu_en,
    input  logic                                  [ALU_SIZE-1:0]               alu_we,
    input  wakeup_pkg::preg_t                     [ALU_SIZE-1:0]               alu_rd,
    input  logic                                  [LOAD_PIPELINE-1:0]          load_en,
    input  logic                                  [LOAD_PIPELINE-1:0]          load_we,
    input  wakeup_pkg::preg_t                     [LOAD_PIPELINE-1:0]          load_rd,
    input  logic                                                               csr_en,
    input  logic                                                               csr_we,
    input  wakeup_pkg::preg_t                                                  csr_rd,
    input  logic                                                               mult_en,
    input  logic                                                               mult_we,
    input  wakeup_pkg::preg_t                                                  mult_rd,
    input  logic                                                               div_en,
    input  logic                                                               div_we,
    input  wakeup_pkg::preg_t                                                  div_rd,
    output logic                                  [ALU_SIZE-1:0]               alu_ready,
    output logic                                  [ALU_SIZE+LOAD_PIPELINE-1:0] wake_en,
    output logic                                  [ALU_SIZE+LOAD_PIPELINE-1:0] wake_we,
    output wakeup_pkg::preg_t                     [ALU_SIZE+LOAD_PIPELINE-1:0] wake_rd
);

    localparam int BUS_SIZE = ALU_SIZE + LOAD_PIPELINE;

    // per-lane view of the unit that borrows the lane, if any
    logic              [ALU_SIZE-1:0] share_en;
    logic              [ALU_SIZE-1:0] share_we;
    wakeup_pkg::preg_t [ALU_SIZE-1:0] share_rd;

    // ****************************************
    // lane sharing map
    // ****************************************
    for (genvar i = 0; i < ALU_SIZE; i++) begin : g_share
        if (i == 0) begin : g_csr
            assign share_en[i] = csr_en;
            assign share_we[i] = csr_we;
            assign share_rd[i] = csr_rd;
        end
        else if (i == 2) begin : g_mult
            assign share_en[i] = mult_en;
            assign share_we[i] = mult_we;
            assign share_rd[i] = mult_rd;
        end
        else if (i == 3) begin : g_div
            assign share_en[i] = div_en;
            assign share_we[i] = div_we;
            assign share_rd[i] = div_rd;
        end
        else begin : g_none
            assign share_en[i] = 1'b0;
            assign share_we[i] = 1'b0;
            assign share_rd[i] = '0;
        end
    end

    // ****************************************
    // alu lanes, unit wins over the slot
    // ****************************************
    for (genvar i = 0; i < ALU_SIZE; i++) begin : g_alu
        assign alu_ready[i] = ~share_en[i]; // slot must retry when low
        assign wake_en[i]   = alu_en[i] | share_en[i];
        assign wake_we[i]   = share_en[i] ? share_we[i] : alu_we[i];
        assign wake_rd[i]   = share_en[i] ? share_rd[i] : alu_rd[i];
    end

    // load lanes sit above the alu lanes
    assign wake_en[BUS_SIZE-1:ALU_SIZE] = load_en;
    assign wake_we[BUS_SIZE-1:ALU_SIZE] = load_we;
    assign wake_rd[BUS_SIZE-1:ALU_SIZE] = load_rd;

endmodule

/* mult_wakeup.sv */
module mult_wakeup #(
    parameter int MULT_LATENCY = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mult_issue,
    input  logic              mult_we,
    input  wakeup_pkg::preg_t mult_rd,
    output logic              mult_en,
    output logic              mult_we_out,
    output wakeup_pkg::preg_t mult_rd_out
);

    // issue to wakeup distance, one stage per cycle
    localparam int DEPTH = MULT_LATENCY - wakeup_pkg::WAKE_AHEAD;

    logic              [DEPTH-1:0] vld;
    logic              [DEPTH-1:0] we_q;
    wakeup_pkg::preg_t [DEPTH-1:0] rd_q;

    // ****************************************
    // valid chain
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end
        else begin
            vld[0] <= mult_issue;
            for (int i = 1; i < DEPTH; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    // payload follows valid
    always_ff @(posedge clk) begin
        we_q[0] <= mult_we;
        rd_q[0] <= mult_rd;
        for (int i = 1; i < DEPTH; i++) begin
            we_q[i] <= we_q[i-1];
            rd_q[i] <= rd_q[i-1];
        end
    end

    assign mult_en     = vld[DEPTH-1];
    assign mult_we_out = we_q[DEPTH-1];
    assign mult_rd_out = rd_q[DEPTH-1];

endmodule

/* div_wakeup.sv */
module div_wakeup (
    input  logic              clk,
    input  logic              rst,
    input  logic              div_issue,
    input  logic              div_we,
    input  wakeup_pkg::preg_t div_rd,
    input  logic [3:0]        div_cycles,
    output logic              div_en,
    output logic              div_we_out,
    output wakeup_pkg::preg_t div_rd_out,
    output logic              div_busy
);

    // latencies up to this value skip the count state
    localparam logic [3:0] LEAD = 4'(wakeup_pkg::WAKE_AHEAD + 1);

    wakeup_pkg::div_state_t state;
    logic [3:0]             remain; // cycles left in DIV_COUNT
    logic                   we_q;
    wakeup_pkg::preg_t      rd_q;
    logic                   accept;

    assign accept = div_issue && (state == wakeup_pkg::DIV_IDLE); // ignored while busy

    // ****************************************
    // divider FSM
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wakeup_pkg::DIV_IDLE;
        end
        else begin
            case (state)
                wakeup_pkg::DIV_IDLE: begin
                    if (div_issue) begin
                        state <= (div_cycles <= LEAD) ? wakeup_pkg::DIV_WAKE
                                                      : wakeup_pkg::DIV_COUNT;
                    end
                end
                wakeup_pkg::DIV_COUNT: begin
                    if (remain == 4'd1) begin
                        state <= wakeup_pkg::DIV_WAKE;
                    end
                end
                wakeup_pkg::DIV_WAKE:  state <= wakeup_pkg::DIV_IDLE;
                default:               state <= wakeup_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            we_q   <= div_we;
            rd_q   <= div_rd;
            remain <= div_cycles - LEAD;
        end
        else if (state == wakeup_pkg::DIV_COUNT) begin
            remain <= remain - 4'd1;
        end
    end

    assign div_en     = (state == wakeup_pkg::DIV_WAKE);
    assign div_we_out = we_q;
    assign div_rd_out = rd_q;
    assign div_busy   = (state != wakeup_pkg::DIV_IDLE); // through the wake cycle

endmodule

/* busy_table.sv */
module busy_table #(
    parameter int LANES = 6
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        alloc_en,
    input  wakeup_pkg::preg_t                           alloc_rd,
    input  logic                            [LANES-1:0] wake_en,
    input  logic                            [LANES-1:0] wake_we,
    input  wakeup_pkg::preg_t               [LANES-1:0] wake_rd,
    input  wakeup_pkg::preg_t                           src1,
    input  wakeup_pkg::preg_t                           src2,
    output logic                                        src1_busy,
    output logic                                        src2_busy
);

    logic [wakeup_pkg::PREG_SIZE-1:0] busy;
    logic [wakeup_pkg::PREG_SIZE-1:0] clear_vec; // regs written back this cycle
    logic [wakeup_pkg::PREG_SIZE-1:0] set_vec;

    // ****************************************
    // clear and set decode
    // ****************************************
    always_comb begin
        clear_vec = '0;
        for (int i = 0; i < LANES; i++) begin
            if (wake_en[i] && wake_we[i]) begin
                clear_vec[wake_rd[i]] = 1'b1;
            end
        end
    end

    always_comb begin
        set_vec = '0;
        if (alloc_en) begin
            set_vec[alloc_rd] = 1'b1;
        end
    end

    // ****************************************
    // pending bits
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end
        else begin
            busy <= (busy & ~clear_vec) | set_vec; // allocation wins
        end
    end

    // forward same-cycle wakeups to the query
    assign src1_busy = busy[src1] & ~clear_vec[src1];
    assign src2_busy = busy[src2] & ~clear_vec[src2];

endmodule

/* wakeup_top.sv */
module wakeup_top #(
    parameter int ALU_SIZE      = 4,
    parameter int LOAD_PIPELINE = 2,
    parameter int MULT_LATENCY  = 4
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    // alu slots
    input  logic              [ALU_SIZE-1:0]                      alu_en,
    input  logic              [ALU_SIZE-1:0]                      alu_we,
    input  wakeup_pkg::preg_t [ALU_SIZE-1:0]                      alu_rd,
    output logic              [ALU_SIZE-1:0]                      alu_ready,
    // load pipelines
    input  logic              [LOAD_PIPELINE-1:0]                 load_en,
    input  logic              [LOAD_PIPELINE-1:0]                 load_we,
    input  wakeup_pkg::preg_t [LOAD_PIPELINE-1:0]                 load_rd,
    // csr unit
    input  logic                                                  csr_en,
    input  logic                                                  csr_we,
    input  wakeup_pkg::preg_t                                     csr_rd,
    // multiplier issue
    input  logic                                                  mult_issue,
    input  logic                                                  mult_we,
    input  wakeup_pkg::preg_t                                     mult_rd,
    // divider issue
    input  logic                                                  div_issue,
    input  logic                                                  div_we,
    input  wakeup_pkg::preg_t                                     div_rd,
    input  logic              [3:0]                               div_cycles,
    output logic                                                  div_busy,
    // wakeup bus
    output logic              [ALU_SIZE+LOAD_PIPELINE-1:0]        wake_en,
    output logic              [ALU_SIZE+LOAD_PIPELINE-1:0]        wake_we,
    output wakeup_pkg::preg_t [ALU_SIZE+LOAD_PIPELINE-1:0]        wake_rd,
    // busy table
    input  logic                                                  alloc_en,
    input  wakeup_pkg::preg_t                                     alloc_rd,
    input  wakeup_pkg::preg_t                                     src1,
    input  wakeup_pkg::preg_t                                     src2,
    output logic                                                  src1_busy,
    output logic                                                  src2_busy
);

    localparam int BUS_SIZE = ALU_SIZE + LOAD_PIPELINE;

    // generator outputs, registered
    logic              mult_wake_en;
    logic              mult_wake_we;
    wakeup_pkg::preg_t mult_wake_rd;
    logic              div_wake_en;
    logic              div_wake_we;
    wakeup_pkg::preg_t div_wake_rd;

    mult_wakeup #(
        .MULT_LATENCY(MULT_LATENCY)
    ) u_mult_wakeup (
        .clk        (clk),
        .rst        (rst),
        .mult_issue (mult_issue),
        .mult_we    (mult_we),
        .mult_rd    (mult_rd),
        .mult_en    (mult_wake_en),
        .mult_we_out(mult_wake_we),
        .mult_rd_out(mult_wake_rd)
    );

    div_wakeup u_div_wakeup (
        .clk       (clk),
        .rst       (rst),
        .div_issue (div_issue),
        .div_we    (div_we),
        .div_rd    (div_rd),
        .div_cycles(div_cycles),
        .div_en    (div_wake_en),
        .div_we_out(div_wake_we),
        .div_rd_out(div_wake_rd),
        .div_busy  (div_busy)
    );

    wakeup_merge #(
        .ALU_SIZE     (ALU_SIZE),
        .LOAD_PIPELINE(LOAD_PIPELINE)
    ) u_wakeup_merge (
        .alu_en   (alu_en),
        .alu_we   (alu_we),
        .alu_rd   (alu_rd),
        .load_en  (load_en),
        .load_we  (load_we),
        .load_rd  (load_rd),
        .csr_en   (csr_en),
        .csr_we   (csr_we),
        .csr_rd   (csr_rd),
        .mult_en  (mult_wake_en),
        .mult_we  (mult_wake_we),
        .mult_rd  (mult_wake_rd),
        .div_en   (div_wake_en),
        .div_we   (div_wake_we),
        .div_rd   (div_wake_rd),
        .alu_ready(alu_ready),
        .wake_en  (wake_en),
        .wake_we  (wake_we),
        .wake_rd  (wake_rd)
    );

    busy_table #(
        .LANES(BUS_SIZE)
    ) u_busy_table (
        .clk      (clk),
        .rst      (rst),
        .alloc_en (alloc_en),
        .alloc_rd (alloc_rd),
        .wake_en  (wake_en),
        .wake_we  (wake_we),
        .wake_rd  (wake_rd),
        .src1     (src1),
        .src2     (src2),
        .src1_busy(src1_busy),
        .src2_busy(src2_busy)
    );

endmodule

/* tb_wakeup.sv */
module tb_wakeup;

    localparam int ALU_SIZE      = 4;
    localparam int LOAD_PIPELINE = 2;
    localparam int MULT_LATENCY  = 4;
    localparam int BUS_SIZE      = ALU_SIZE + LOAD_PIPELINE;
    localparam int PERIOD        = 20;
    localparam int RESET_CYCLES  = 5;
    localparam int MUL_DIST      = MULT_LATENCY - wakeup_pkg::WAKE_AHEAD;
    localparam int MULT_COUNT    = 4;
    localparam int LOAD_ROUNDS   = 8;
    localparam int MIX_ROUNDS    = 40;
    // cycles per test with divides counted at the longest latency
    localparam int BUDGET = RESET_CYCLES + wakeup_pkg::PREG_SIZE / 2 + 3
                          + (MULT_COUNT + MUL_DIST + 2) + 4 * 16 + LOAD_ROUNDS
                          + 11 + MIX_ROUNDS;
    localparam int MARGIN = 50;

    logic                                           clk;
    logic                                           rst;
    logic              [ALU_SIZE-1:0]               alu_en;
    logic              [ALU_SIZE-1:0]               alu_we;
    wakeup_pkg::preg_t [ALU_SIZE-1:0]               alu_rd;
    logic              [ALU_SIZE-1:0]               alu_ready;
    logic              [LOAD_PIPELINE-1:0]          load_en;
    logic              [LOAD_PIPELINE-1:0]          load_we;
    wakeup_pkg::preg_t [LOAD_PIPELINE-1:0]          load_rd;
    logic                                           csr_en;
    logic                                           csr_we;
    wakeup_pkg::preg_t                              csr_rd;
    logic                                           mult_issue;
    logic                                           mult_we;
    wakeup_pkg::preg_t                              mult_rd;
    logic                                           div_issue;
    logic                                           div_we;
    wakeup_pkg::preg_t                              div_rd;
    logic              [3:0]                        div_cycles;
    logic                                           div_busy;
    logic              [BUS_SIZE-1:0]               wake_en;
    logic              [BUS_SIZE-1:0]               wake_we;
    wakeup_pkg::preg_t [BUS_SIZE-1:0]               wake_rd;
    logic                                           alloc_en;
    wakeup_pkg::preg_t                              alloc_rd;
    wakeup_pkg::preg_t                              src1;
    wakeup_pkg::preg_t                              src2;
    logic                                           src1_busy;
    logic                                           src2_busy;

    logic [31:0] seed = 32'hedb6_b761;
    string       cur_test;
    int          errors      = 0;
    int          checks      = 0;
    int          tests_run   = 0;
    int          test_errors = 0;

    wakeup_top #(
        .ALU_SIZE     (ALU_SIZE),
        .LOAD_PIPELINE(LOAD_PIPELINE),
        .MULT_LATENCY (MULT_LATENCY)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ****************************************
    // helpers
    // ****************************************
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        seed = xorshift32(seed);
        return seed;
    endfunction

    task automatic clear_inputs();
        alu_en     = '0;
        alu_we     = '0;
        alu_rd     = '0;
        load_en    = '0;
        load_we    = '0;
        load_rd    = '0;
        csr_en     = 1'b0;
        csr_we     = 1'b0;
        csr_rd     = '0;
        mult_issue = 1'b0;
        mult_we    = 1'b0;
        mult_rd    = '0;
        div_issue  = 1'b0;
        div_we     = 1'b0;
        div_rd     = '0;
        div_cycles = '0;
        alloc_en   = 1'b0;
        alloc_rd   = '0;
        src1       = '0;
        src2       = '0;
    endtask

    task automatic begin_cycle(); // falling edge with inputs back to idle
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic settle(); // sample well before the rising edge
        #(PERIOD / 4);
    endtask

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("%-14s ok", cur_test);
        end
        else begin
            $display("%-14s %0d errors", cur_test, errors - test_errors);
        end
    endtask

    // ****************************************
    // tests
    // ****************************************
    task automatic reset_state();
        start_test("reset_state");
        for (int r = 0; r < wakeup_pkg::PREG_SIZE / 2; r++) begin
            begin_cycle();
            src1 = 6'(2 * r);
            src2 = 6'(2 * r + 1);
            settle();
            expect_eq("wake_en", 0, wake_en);
            expect_eq("alu_ready", 4'hf, alu_ready);
            expect_eq("div_busy", 0, div_busy);
            expect_eq($sformatf("busy %0d", 2 * r), 0, src1_busy);
            expect_eq($sformatf("busy %0d", 2 * r + 1), 0, src2_busy);
        end
        finish_test();
    endtask

    task automatic csr_priority();
        start_test("csr_priority");
        for (int k = 0; k < 3; k++) begin
            begin_cycle();
            alu_en = '1;
            alu_we = (k == 1) ? 4'b1110 : 4'b1111;
            for (int i = 0; i < ALU_SIZE; i++) begin
                alu_rd[i] = 6'(10 + i);
            end
            csr_en = (k < 2); // csr idle in the last round
            csr_we = (k == 1);
            csr_rd = 6'd40;
            settle();
            expect_eq("lane0 en", 1, wake_en[0]);
            expect_eq("lane0 we", k != 0, wake_we[0]);
            expect_eq("lane0 rd", (k < 2) ? 40 : 10, wake_rd[0]);
            expect_eq("alu_ready", (k < 2) ? 4'b1110 : 4'b1111, alu_ready);
            for (int i = 1; i < ALU_SIZE; i++) begin
                expect_eq($sformatf("lane%0d rd", i), 10 + i, wake_rd[i]);
            end
        end
        finish_test();
    endtask

    task automatic mult_latency();
        int j;
        start_test("mult_latency");
        for (int k = 0; k < MULT_COUNT + MUL_DIST + 2; k++) begin
            begin_cycle();
            if (k < MULT_COUNT) begin
                mult_issue = 1'b1;
                mult_we    = (k % 2 == 0);
                mult_rd    = 6'(20 + k);
            end
            alu_en[2] = 1'b1; // competing slot
            alu_we[2] = 1'b1;
            alu_rd[2] = 6'd63;
            settle();
            j = k - MUL_DIST;
            expect_eq("lane2 en", 1, wake_en[2]);
            if (j >= 0 && j < MULT_COUNT) begin
                expect_eq("ready2", 0, alu_ready[2]);
                expect_eq("lane2 rd", 20 + j, wake_rd[2]);
                expect_eq("lane2 we", j % 2 == 0, wake_we[2]);
            end
            else begin
                expect_eq("ready2", 1, alu_ready[2]);
                expect_eq("lane2 rd", 63, wake_rd[2]);
            end
        end
        finish_test();
    endtask

    task automatic div_variable();
        int lat[4] = '{3, 5, 9, 15};
        int n;
        start_test("div_variable");
        for (int d = 0; d < 4; d++) begin
            n = lat[d];
            begin_cycle();
            div_issue  = 1'b1;
            div_we     = (d % 2 == 0);
            div_rd     = 6'(30 + d);
            div_cycles = 4'(n);
            settle();
            expect_eq("busy at issue", 0, div_busy);
            for (int k = 1; k <= n; k++) begin
                begin_cycle();
                if (k == 1) begin // dropped while busy
                    div_issue  = 1'b1;
                    div_we     = 1'b1;
                    div_rd     = 6'd50;
                    div_cycles = 4'd3;
                end
                settle();
                expect_eq($sformatf("div_busy n=%0d k=%0d", n, k), k <= n - 2, div_busy);
                expect_eq($sformatf("lane3 en n=%0d k=%0d", n, k), k == n - 2, wake_en[3]);
                expect_eq("ready3", k != n - 2, alu_ready[3]);
                if (k == n - 2) begin
                    expect_eq("lane3 rd", 30 + d, wake_rd[3]);
                    expect_eq("lane3 we", d % 2 == 0, wake_we[3]);
                end
            end
        end
        finish_test();
    endtask

    task automatic load_lanes();
        logic [31:0] r;
        start_test("load_lanes");
        for (int k = 0; k < LOAD_ROUNDS; k++) begin
            begin_cycle();
            r          = rand32();
            load_en    = r[1:0];
            load_we    = r[3:2];
            load_rd[0] = r[9:4];
            load_rd[1] = r[15:10];
            settle();
            expect_eq("alu lanes en", 0, wake_en[ALU_SIZE-1:0]);
            for (int j = 0; j < LOAD_PIPELINE; j++) begin
                expect_eq($sformatf("load%0d en", j), r[j], wake_en[ALU_SIZE+j]);
                expect_eq($sformatf("load%0d we", j), r[2+j], wake_we[ALU_SIZE+j]);
                expect_eq($sformatf("load%0d rd", j), r[4+6*j +: 6], wake_rd[ALU_SIZE+j]);
            end
        end
        finish_test();
    endtask

    // one cycle with queries fixed on registers 7 and 8
    task automatic busy_step(input logic a_en, input logic w_en, input logic w_we,
                             input wakeup_pkg::preg_t rd, input logic exp1, input logic exp2);
        begin_cycle();
        alloc_en  = a_en;
        alloc_rd  = rd;
        alu_en[1] = w_en; // lane 1 is never shared
        alu_we[1] = w_we;
        alu_rd[1] = rd;
        src1      = 6'd7;
        src2      = 6'd8;
        settle();
        expect_eq("src1_busy", exp1, src1_busy);
        expect_eq("src2_busy", exp2, src2_busy);
    endtask

    task automatic busy_tracking();
        start_test("busy_table");
        busy_step(1, 0, 0, 6'd7, 0, 0);
        busy_step(1, 0, 0, 6'd8, 1, 0);
        busy_step(0, 0, 0, 6'd0, 1, 1);
        busy_step(0, 1, 1, 6'd7, 0, 1); // forwarded clear
        busy_step(0, 0, 0, 6'd0, 0, 1);
        busy_step(0, 1, 0, 6'd8, 0, 1); // no write so it stays busy
        busy_step(0, 0, 0, 6'd0, 0, 1);
        busy_step(1, 1, 1, 6'd8, 0, 0); // alloc and clear together
        busy_step(0, 0, 0, 6'd0, 0, 1);
        busy_step(0, 1, 1, 6'd8, 0, 0);
        busy_step(0, 0, 0, 6'd0, 0, 0);
        finish_test();
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] q;
        logic        share;
        logic        exp_en;
        start_test("random_mix");
        for (int k = 0; k < MIX_ROUNDS; k++) begin
            begin_cycle();
            r = rand32();
            q = rand32();
            alu_en = r[3:0];
            alu_we = r[7:4];
            csr_en = r[8];
            csr_we = r[9];
            load_en = r[11:10];
            load_we = r[13:12];
            load_rd[0] = r[19:14];
            load_rd[1] = r[25:20];
            for (int i = 0; i < ALU_SIZE; i++) begin
                alu_rd[i] = q[6*i +: 6];
            end
            csr_rd = q[29:24];
            settle();
            for (int i = 0; i < ALU_SIZE; i++) begin
                share  = (i == 0) && r[8];
                exp_en = r[i] | share;
                expect_eq($sformatf("ready%0d", i), !share, alu_ready[i]);
                expect_eq($sformatf("lane%0d en", i), exp_en, wake_en[i]);
                if (exp_en) begin
                    expect_eq($sformatf("lane%0d we", i), share ? r[9] : r[4+i], wake_we[i]);
                    expect_eq($sformatf("lane%0d rd", i),
                              share ? q[29:24] : q[6*i +: 6], wake_rd[i]);
                end
            end
            for (int j = 0; j < LOAD_PIPELINE; j++) begin
                expect_eq($sformatf("load%0d en", j), r[10+j], wake_en[ALU_SIZE+j]);
                if (r[10+j]) begin
                    expect_eq($sformatf("load%0d we", j), r[12+j], wake_we[ALU_SIZE+j]);
                    expect_eq($sformatf("load%0d rd", j), r[14+6*j +: 6],
                              wake_rd[ALU_SIZE+j]);
                end
            end
        end
        finish_test();
    endtask

    // ****************************************
    // sequence and watchdog
    // ****************************************
    initial begin
        clear_inputs();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state();
        csr_priority();
        mult_latency();
        div_variable();
        load_lanes();
        busy_tracking();
        random_mix();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end
        else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (BUDGET + MARGIN) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", BUDGET + MARGIN);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* verilog.f */
wakeup_pkg.sv
wakeup_merge.sv
mult_wakeup.sv
div_wakeup.sv
busy_table.sv
wakeup_top.sv
tb_wakeup.sv

/* Bender.yml */
package:
  name: wakeup

sources:
  - wakeup_pkg.sv
  - wakeup_merge.sv
  - mult_wakeup.sv
  - div_wakeup.sv
  - busy_table.sv
  - wakeup_top.sv
  - target: simulation
    files:
      - tb_wakeup.sv
